// File: soc_pkg.sv
// SoC bus widths
// Address map with region decode and GPIO register offsets
package soc_pkg;

    localparam int WB_ADR_W = 32;
    localparam int WB_DAT_W = 32;

    // Region field occupies address bits 19:16
    localparam int REGION_LSB = 16;
    localparam int REGION_W   = 4;

    localparam logic [REGION_W-1:0] REGION_AUDIO = 4'd1;
    localparam logic [REGION_W-1:0] REGION_GPIO  = 4'd2;
    // Every other region value is unmapped

    // GPIO register offsets within the GPIO region
    localparam logic [3:0] GPIO_OUT_OFS = 4'h0;
    localparam logic [3:0] GPIO_IN_OFS  = 4'h4;

endpackage

// File: audio_pkg.sv
// Audio sample width and register offsets
// Sample pair and control word layouts, status field positions
package audio_pkg;

    localparam int SAMPLE_W = 16;
    // FIFO fill level as reported in status
    localparam int LEVEL_W  = 8;

    localparam logic [3:0] AUDIO_CTRL_OFS   = 4'h0;
    localparam logic [3:0] AUDIO_STATUS_OFS = 4'h4;
    localparam logic [3:0] AUDIO_DATA_OFS   = 4'h8;

    // Status bits above the level field
    localparam int STAT_LOW_BIT      = 8;
    localparam int STAT_UNDERRUN_BIT = 9;
    localparam int STAT_OVERFLOW_BIT = 10;

    // Left channel in the upper half, also the FIFO word
    typedef struct packed {
        logic [SAMPLE_W-1:0] left;
        logic [SAMPLE_W-1:0] right;
    } sample_pair_t;

    typedef struct packed {
        logic [15:0] reserved_hi;
        logic [7:0]  low_threshold;
        logic [6:0]  reserved_lo;
        logic        enable;
    } audio_ctrl_t;

    // One bus word, read as samples for DATA or as fields for CTRL
    typedef union packed {
        sample_pair_t pair;
        audio_ctrl_t  ctrl;
    } audio_word_u;

endpackage

// File: wb_if.sv
// Wishbone classic bus bundle
// Master and slave modports
`timescale 1ns/100ps

interface wb_if;

    logic [soc_pkg::WB_ADR_W-1:0] adr;
    logic [soc_pkg::WB_DAT_W-1:0] dat_w;
    logic [soc_pkg::WB_DAT_W-1:0] dat_r;
    logic                         we;
    logic                         stb;
    logic                         cyc;
    logic                         ack;

    modport master (
        output adr, dat_w, we, stb, cyc,
        input  dat_r, ack
    );

    modport slave (
        input  adr, dat_w, we, stb, cyc,
        output dat_r, ack
    );

endinterface

// File: sample_fifo_if.sv
// Sample FIFO port bundle
// Writer, reader and FIFO-side modports
`timescale 1ns/100ps

interface sample_fifo_if;

    logic                          push;
    audio_pkg::sample_pair_t       wdata;
    logic                          full;
    logic [audio_pkg::LEVEL_W-1:0] level;
    logic                          pop;
    // Head word, valid while empty is low
    audio_pkg::sample_pair_t       rdata;
    logic                          empty;

    modport writer (
        output push, wdata,
        input  full, level
    );

    modport reader (
        output pop,
        input  rdata, empty
    );

    modport fifo (
        input  push, wdata, pop,
        output full, level, rdata, empty
    );

endinterface

// File: wb_xbar.sv
// Wishbone crossbar, one master to audio and GPIO slaves
// Answers unmapped regions with a zero-data ack
`timescale 1ns/100ps

module wb_xbar (
    input  logic clk,
    input  logic rst_i,
    wb_if.slave  bus_i,
    wb_if.master audio_o,
    wb_if.master gpio_o
);

    logic [soc_pkg::REGION_W-1:0] region;
    logic                         sel_audio;
    logic                         sel_gpio;
    logic                         sel_none;
    logic                         none_ack;

    assign region    = bus_i.adr[soc_pkg::REGION_LSB +: soc_pkg::REGION_W];
    assign sel_audio = (region == soc_pkg::REGION_AUDIO);
    assign sel_gpio  = (region == soc_pkg::REGION_GPIO);
    assign sel_none  = ~sel_audio & ~sel_gpio;

    // Address, data and cycle go to both, strobe only to the selected one
    assign audio_o.adr   = bus_i.adr;
    assign audio_o.dat_w = bus_i.dat_w;
    assign audio_o.we    = bus_i.we;
    assign audio_o.cyc   = bus_i.cyc;
    assign audio_o.stb   = bus_i.stb & sel_audio;

    assign gpio_o.adr   = bus_i.adr;
    assign gpio_o.dat_w = bus_i.dat_w;
    assign gpio_o.we    = bus_i.we;
    assign gpio_o.cyc   = bus_i.cyc;
    assign gpio_o.stb   = bus_i.stb & sel_gpio;

    assign bus_i.ack   = sel_audio ? audio_o.ack :
                         sel_gpio  ? gpio_o.ack  : none_ack;
    assign bus_i.dat_r = sel_audio ? audio_o.dat_r :
                         sel_gpio  ? gpio_o.dat_r  : '0;

    // Unmapped slot acks with the same one-cycle latency as real slaves
    always_ff @(posedge clk) begin
        if (rst_i) begin
            none_ack <= 1'b0;
        end else begin
            none_ack <= bus_i.stb & bus_i.cyc & sel_none & ~none_ack;
        end
    end

    assert property (@(posedge clk) disable iff (rst_i) audio_o.ack |-> audio_o.stb)
        else $error("audio slave acked without its strobe");

    assert property (@(posedge clk) disable iff (rst_i) gpio_o.ack |-> gpio_o.stb)
        else $error("GPIO slave acked without its strobe");

endmodule

// File: audio_regs.sv
// Audio register block on Wishbone
// CTRL, STATUS and DATA push, sticky error bits, FIFO-low flag
`timescale 1ns/100ps

module audio_regs #(
    parameter int FIFO_DEPTH = 8
) (
    input  logic          clk,
    input  logic          rst_i,
    wb_if.slave           bus_i,
    sample_fifo_if.writer fifo_o,
    input  logic          underrun_i,
    output logic          enable_o,
    output logic          fifo_low_o
);

    audio_pkg::audio_word_u       wr_word;
    audio_pkg::audio_word_u       ctrl_word;
    logic [soc_pkg::WB_DAT_W-1:0] status_word;
    logic [7:0]                   low_threshold;
    logic                         underrun_q;
    logic                         overflow_q;
    logic                         access;
    logic                         ctrl_wr;
    logic                         data_wr;

    assign wr_word = bus_i.dat_w;

    // First cycle of a strobe only
    assign access  = bus_i.stb & bus_i.cyc & ~bus_i.ack;
    assign ctrl_wr = access & bus_i.we & (bus_i.adr[3:0] == audio_pkg::AUDIO_CTRL_OFS);
    assign data_wr = access & bus_i.we & (bus_i.adr[3:0] == audio_pkg::AUDIO_DATA_OFS);

    // Pushes to a full FIFO are dropped here
    assign fifo_o.push  = data_wr & ~fifo_o.full;
    assign fifo_o.wdata = wr_word.pair;

    assign fifo_low_o = enable_o & (fifo_o.level < low_threshold);

    always_comb begin
        ctrl_word                    = '0;
        ctrl_word.ctrl.enable        = enable_o;
        ctrl_word.ctrl.low_threshold = low_threshold;
    end

    always_comb begin
        status_word                                 = '0;
        status_word[audio_pkg::LEVEL_W-1:0]         = fifo_o.level;
        status_word[audio_pkg::STAT_LOW_BIT]        = fifo_low_o;
        status_word[audio_pkg::STAT_UNDERRUN_BIT]   = underrun_q;
        status_word[audio_pkg::STAT_OVERFLOW_BIT]   = overflow_q;
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            bus_i.ack     <= 1'b0;
            enable_o      <= 1'b0;
            low_threshold <= '0;
            underrun_q    <= 1'b0;
            overflow_q    <= 1'b0;
        end else begin
            bus_i.ack <= access;
            if (ctrl_wr) begin
                enable_o      <= wr_word.ctrl.enable;
                low_threshold <= wr_word.ctrl.low_threshold;
                // Any CTRL write clears the sticky bits
                underrun_q    <= 1'b0;
                overflow_q    <= 1'b0;
            end else begin
                if (underrun_i) begin
                    underrun_q <= 1'b1;
                end
                if (data_wr && fifo_o.full) begin
                    overflow_q <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (access && !bus_i.we) begin
            case (bus_i.adr[3:0])
                audio_pkg::AUDIO_CTRL_OFS:   bus_i.dat_r <= ctrl_word;
                audio_pkg::AUDIO_STATUS_OFS: bus_i.dat_r <= status_word;
                default:                     bus_i.dat_r <= '0;
            endcase
        end
    end

    assert property (@(posedge clk) disable iff (rst_i) fifo_o.level <= FIFO_DEPTH)
        else $error("FIFO level beyond its depth");

endmodule

// File: sample_fifo.sv
// Synchronous FIFO of stereo sample pairs
// Circular buffer with fill level
`timescale 1ns/100ps

module sample_fifo #(
    parameter int FIFO_DEPTH = 8
) (
    input  logic        clk,
    input  logic        rst_i,
    sample_fifo_if.fifo port_i
);

    localparam int PTR_W = $clog2(FIFO_DEPTH);
    localparam logic [audio_pkg::LEVEL_W-1:0] DEPTH_LVL = audio_pkg::LEVEL_W'(FIFO_DEPTH);

    audio_pkg::sample_pair_t       mem [FIFO_DEPTH];
    logic [PTR_W-1:0]              wr_ptr;
    logic [PTR_W-1:0]              rd_ptr;
    logic [audio_pkg::LEVEL_W-1:0] count;
    logic                          do_push;
    logic                          do_pop;

    assign port_i.full  = (count == DEPTH_LVL);
    assign port_i.empty = (count == '0);
    assign port_i.level = count;
    assign port_i.rdata = mem[rd_ptr];

    assign do_push = port_i.push & ~port_i.full;
    assign do_pop  = port_i.pop & ~port_i.empty;

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= port_i.wdata;
        end
    end

    // Pointers wrap naturally, depth is a power of two
    always_ff @(posedge clk) begin
        if (rst_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

    assert property (@(posedge clk) disable iff (rst_i) port_i.push |-> !port_i.full)
        else $error("push into a full FIFO");

    assert property (@(posedge clk) disable iff (rst_i) port_i.pop |-> !port_i.empty)
        else $error("pop from an empty FIFO");

endmodule

// File: i2s_bit_timer.sv
// I2S bit clock and word select generator
// Emits a strobe on each falling bit clock and at frame start
`timescale 1ns/100ps

module i2s_bit_timer #(
    parameter int CLK_DIV = 4
) (
    input  logic clk,
    input  logic rst_i,
    output logic sclk_o,
    output logic lrclk_o,
    output logic bit_fall_o,
    output logic frame_start_o
);

    localparam int DIV_W = (CLK_DIV > 1) ? $clog2(CLK_DIV) : 1;
    localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(CLK_DIV - 1);

    logic [DIV_W-1:0] div_cnt;
    logic [4:0]       bit_cnt;
    logic             half_tick;

    assign half_tick = (div_cnt == DIV_LAST);

    // sclk goes low on the edge that ends this cycle
    assign bit_fall_o    = half_tick & sclk_o;
    assign frame_start_o = bit_fall_o & (bit_cnt == 5'd31);

    // Left channel while low, right while high
    assign lrclk_o = bit_cnt[4];

    always_ff @(posedge clk) begin
        if (rst_i) begin
            div_cnt <= '0;
            sclk_o  <= 1'b0;
            bit_cnt <= '0;
        end else begin
            if (half_tick) begin
                div_cnt <= '0;
                sclk_o  <= ~sclk_o;
            end else begin
                div_cnt <= div_cnt + 1'b1;
            end
            if (bit_fall_o) begin
                bit_cnt <= bit_cnt + 1'b1;
            end
        end
    end

endmodule

// File: i2s_tx_fsm.sv
// I2S transmit frame FSM
// Pops one sample pair per frame and shifts it out MSB first
`timescale 1ns/100ps

module i2s_tx_fsm (
    input  logic          clk,
    input  logic          rst_i,
    input  logic          enable_i,
    input  logic          bit_fall_i,
    input  logic          frame_start_i,
    sample_fifo_if.reader fifo_i,
    output logic          sdata_o,
    output logic          underrun_o
);

    localparam logic [1:0] ST_IDLE  = 2'd0;
    localparam logic [1:0] ST_LOAD  = 2'd1;
    localparam logic [1:0] ST_SHIFT = 2'd2;
    localparam int FRAME_W = 2 * audio_pkg::SAMPLE_W;

    logic [1:0]         state;
    logic [FRAME_W-1:0] shreg;
    logic               load_evt;

    // A new frame is fetched only once armed and still enabled
    assign load_evt   = frame_start_i & enable_i & (state != ST_IDLE);
    assign fifo_i.pop = load_evt & ~fifo_i.empty;
    assign underrun_o = load_evt & fifo_i.empty;

    assign sdata_o = shreg[FRAME_W-1];

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state <= ST_IDLE;
            shreg <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    shreg <= '0;
                    if (enable_i) begin
                        state <= ST_LOAD;
                    end
                end
                // Waiting for the first frame boundary
                ST_LOAD: begin
                    if (!enable_i) begin
                        state <= ST_IDLE;
                    end else if (frame_start_i) begin
                        state <= ST_SHIFT;
                        shreg <= fifo_i.pop ? fifo_i.rdata : '0;
                    end
                end
                ST_SHIFT: begin
                    if (frame_start_i) begin
                        if (enable_i) begin
                            shreg <= fifo_i.pop ? fifo_i.rdata : '0;
                        end else begin
                            state <= ST_IDLE;
                            shreg <= '0;
                        end
                    end else if (bit_fall_i) begin
                        shreg <= {shreg[FRAME_W-2:0], 1'b0};
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // Serial data only moves on a falling bit clock
    assert property (@(posedge clk) disable iff (rst_i)
        !$stable(sdata_o) |-> $past(bit_fall_i))
        else $error("serial data changed away from a falling bit clock");

endmodule

// File: gpio_port.sv
// GPIO port on Wishbone
// Output register with readback, two-flop synchronized inputs
`timescale 1ns/100ps

module gpio_port (
    input  logic        clk,
    input  logic        rst_i,
    wb_if.slave         bus_i,
    input  logic [14:0] gpio_i,
    input  logic        irq_i,
    output logic [15:0] gpio_o
);

    logic [14:0] sync_meta;
    logic [14:0] sync_q;
    logic        access;

    assign access = bus_i.stb & bus_i.cyc & ~bus_i.ack;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            bus_i.ack <= 1'b0;
            gpio_o    <= '0;
            sync_meta <= '0;
            sync_q    <= '0;
        end else begin
            bus_i.ack <= access;
            sync_meta <= gpio_i;
            sync_q    <= sync_meta;
            if (access && bus_i.we && bus_i.adr[3:0] == soc_pkg::GPIO_OUT_OFS) begin
                gpio_o <= bus_i.dat_w[15:0];
            end
        end
    end

    // irq line sits in the top input bit
    always_ff @(posedge clk) begin
        if (access && !bus_i.we) begin
            case (bus_i.adr[3:0])
                soc_pkg::GPIO_OUT_OFS: bus_i.dat_r <= {16'b0, gpio_o};
                soc_pkg::GPIO_IN_OFS:  bus_i.dat_r <= {16'b0, irq_i, sync_q};
                default:               bus_i.dat_r <= '0;
            endcase
        end
    end

endmodule

// File: audio_soc_top.sv
// Audio and GPIO subsystem top level
// Wishbone slave port, crossbar, audio path and GPIO port
`timescale 1ns/100ps

module audio_soc_top #(
    parameter int FIFO_DEPTH = 8,
    parameter int CLK_DIV    = 4
) (
    input  logic                         clk,
    input  logic                         rst_i,
    input  logic [soc_pkg::WB_ADR_W-1:0] wb_adr_i,
    input  logic [soc_pkg::WB_DAT_W-1:0] wb_dat_i,
    output logic [soc_pkg::WB_DAT_W-1:0] wb_dat_o,
    input  logic                         wb_we_i,
    input  logic                         wb_stb_i,
    input  logic                         wb_cyc_i,
    output logic                         wb_ack_o,
    input  logic [14:0]                  gpio_i,
    output logic [15:0]                  gpio_o,
    output logic                         i2s_sclk_o,
    output logic                         i2s_lrclk_o,
    output logic                         i2s_sdata_o,
    output logic                         fifo_low_o
);

    wb_if host_bus();
    wb_if audio_bus();
    wb_if gpio_bus();
    sample_fifo_if fifo_port();

    logic enable;
    logic underrun;
    logic bit_fall;
    logic frame_start;

    // Bus from the CPU side
    assign host_bus.adr   = wb_adr_i;
    assign host_bus.dat_w = wb_dat_i;
    assign host_bus.we    = wb_we_i;
    assign host_bus.stb   = wb_stb_i;
    assign host_bus.cyc   = wb_cyc_i;
    assign wb_dat_o       = host_bus.dat_r;
    assign wb_ack_o       = host_bus.ack;

    wb_xbar xbar(.clk(clk), .rst_i(rst_i), .bus_i(host_bus), .audio_o(audio_bus),
        .gpio_o(gpio_bus));

    audio_regs #(.FIFO_DEPTH(FIFO_DEPTH)) regs(
        .clk(clk), .rst_i(rst_i), .bus_i(audio_bus), .fifo_o(fifo_port),
        .underrun_i(underrun), .enable_o(enable), .fifo_low_o(fifo_low_o));

    sample_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) sample_buf(
        .clk(clk), .rst_i(rst_i), .port_i(fifo_port));

    i2s_bit_timer #(.CLK_DIV(CLK_DIV)) bit_timer(
        .clk(clk), .rst_i(rst_i), .sclk_o(i2s_sclk_o), .lrclk_o(i2s_lrclk_o),
        .bit_fall_o(bit_fall), .frame_start_o(frame_start));

    i2s_tx_fsm tx(
        .clk(clk), .rst_i(rst_i), .enable_i(enable), .bit_fall_i(bit_fall),
        .frame_start_i(frame_start), .fifo_i(fifo_port), .sdata_o(i2s_sdata_o),
        .underrun_o(underrun));

    // FIFO-low flag doubles as the GPIO interrupt input
    gpio_port gpio(
        .clk(clk), .rst_i(rst_i), .bus_i(gpio_bus), .gpio_i(gpio_i),
        .irq_i(fifo_low_o), .gpio_o(gpio_o));

endmodule

// File: tb_clock_gen.sv
// Testbench clock and reset source
// 10 ns clock, reset held for a set number of cycles
`timescale 1ns/100ps

module tb_clock_gen #(
    parameter int RESET_CYCLES = 8
) (
    output logic clk_o,
    output logic rst_o
);

    initial begin
        clk_o = 1'b0;
        forever #5 clk_o = ~clk_o;
    end

    // Release on a falling edge, like every other DUT input
    initial begin
        rst_o = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        rst_o = 1'b0;
    end

endmodule

// File: tb_audio_soc.sv
// Testbench for the audio and GPIO subsystem
// Stimulus table, Wishbone tasks, I2S frame capture and checks
`timescale 1ns/100ps

module tb_audio_soc;

    localparam int ACK_TIMEOUT   = 20;
    localparam int FRAME_TIMEOUT = 700;
    localparam int TBL_MAX       = 16;
    localparam int OP_WR         = 0;
    localparam int OP_RD         = 1;
    localparam int OP_PIN        = 2;
    localparam int OP_SETIN      = 3;

    logic        clk;
    logic        rst;
    logic [31:0] wb_adr;
    logic [31:0] wb_dat_w;
    logic [31:0] wb_dat_r;
    logic        wb_we;
    logic        wb_stb;
    logic        wb_cyc;
    logic        wb_ack;
    logic [14:0] gpio_in;
    logic [15:0] gpio_out;
    logic        sclk;
    logic        lrclk;
    logic        sdata;
    logic        fifo_low;

    integer seed = 4840;
    int     pass_count = 0;
    int     fail_count = 0;

    string       step_name [TBL_MAX];
    int          step_op   [TBL_MAX];
    logic [31:0] step_adr  [TBL_MAX];
    logic [31:0] step_dat  [TBL_MAX];
    logic [31:0] step_exp  [TBL_MAX];
    int          step_cnt = 0;

    audio_pkg::sample_pair_t frames [$];
    audio_pkg::sample_pair_t sent [$];
    logic [31:0] cap_shift = '0;
    int          cap_bits = 0;
    logic        cap_prev_sclk = 1'b0;
    logic        cap_rise_lr = 1'b0;

    tb_clock_gen #(.RESET_CYCLES(8)) clock_gen(.clk_o(clk), .rst_o(rst));

    audio_soc_top #(.FIFO_DEPTH(8), .CLK_DIV(4)) uut(
        .clk(clk), .rst_i(rst), .wb_adr_i(wb_adr), .wb_dat_i(wb_dat_w),
        .wb_dat_o(wb_dat_r), .wb_we_i(wb_we), .wb_stb_i(wb_stb), .wb_cyc_i(wb_cyc),
        .wb_ack_o(wb_ack), .gpio_i(gpio_in), .gpio_o(gpio_out), .i2s_sclk_o(sclk),
        .i2s_lrclk_o(lrclk), .i2s_sdata_o(sdata), .fifo_low_o(fifo_low));

    // Receiver side, one bit per rising sclk, frames realigned on lrclk fall
    always @(negedge clk) begin
        if (!cap_prev_sclk && sclk) begin
            if (!lrclk && cap_rise_lr) begin
                cap_bits = 0;
            end
            cap_shift   = {cap_shift[30:0], sdata};
            cap_bits    = cap_bits + 1;
            cap_rise_lr = lrclk;
            if (cap_bits == 32) begin
                frames.push_back(cap_shift);
                cap_bits = 0;
            end
        end
        cap_prev_sclk = sclk;
    end

    function automatic logic [31:0] region_addr(input logic [3:0] region,
                                                input logic [3:0] ofs);
        logic [31:0] a;
        a = '0;
        a[soc_pkg::REGION_LSB +: soc_pkg::REGION_W] = region;
        a[3:0] = ofs;
        return a;
    endfunction

    // CTRL layout: enable in bit 0, threshold in 15:8
    function automatic logic [31:0] make_ctrl(input logic en, input logic [7:0] thr);
        return {16'b0, thr, 7'b0, en};
    endfunction

    function automatic logic [31:0] make_status(input logic [7:0] level, input logic low,
                                                input logic und, input logic ovf);
        return {21'b0, ovf, und, low, level};
    endfunction

    function automatic audio_pkg::sample_pair_t random_pair();
        logic [31:0] w;
        w = $random(seed);
        if (w == 32'b0) begin
            w = 32'h1;
        end
        return w;
    endfunction

    task automatic check_word(input string nm, input logic [31:0] exp, input logic [31:0] act);
        if (act === exp) begin
            pass_count++;
            $display("PASS %s", nm);
        end else begin
            fail_count++;
            $display("CHECK FAILED %s expected %h actual %h", nm, exp, act);
        end
    endtask

    task automatic check_pair(input string nm, input audio_pkg::sample_pair_t exp,
                              input audio_pkg::sample_pair_t act);
        if (act === exp) begin
            pass_count++;
            $display("PASS %s", nm);
        end else begin
            fail_count++;
            $display("CHECK FAILED %s expected L=%h R=%h actual L=%h R=%h",
                     nm, exp.left, exp.right, act.left, act.right);
        end
    endtask

    task automatic check_bit(input string nm, input logic exp, input logic act);
        if (act === exp) begin
            pass_count++;
            $display("PASS %s", nm);
        end else begin
            fail_count++;
            $display("CHECK FAILED %s expected %b actual %b", nm, exp, act);
        end
    endtask

    // Holds the request through the clock edge that samples ack
    task automatic bus_access(input logic [31:0] adr, input logic [31:0] dat,
                              input logic we, output logic [31:0] rd);
        int   n;
        logic got;
        n   = 0;
        got = 1'b0;
        rd  = '0;
        @(negedge clk);
        wb_adr   = adr;
        wb_dat_w = dat;
        wb_we    = we;
        wb_stb   = 1'b1;
        wb_cyc   = 1'b1;
        while (!got && n < ACK_TIMEOUT) begin
            @(negedge clk);
            n++;
            if (wb_ack) begin
                got = 1'b1;
                rd  = wb_dat_r;
            end
        end
        // Ack cycle ends on the next rising edge
        if (got) begin
            @(negedge clk);
        end
        wb_stb = 1'b0;
        wb_cyc = 1'b0;
        wb_we  = 1'b0;
        if (!got) begin
            fail_count++;
            $display("ERROR no bus ack for the access at address %h", adr);
        end
    endtask

    task automatic bus_write(input logic [31:0] adr, input logic [31:0] dat);
        logic [31:0] unused;
        bus_access(adr, dat, 1'b1, unused);
    endtask

    task automatic bus_read(input logic [31:0] adr, output logic [31:0] dat);
        bus_access(adr, 32'b0, 1'b0, dat);
    endtask

    task automatic add_step(input string nm, input int op, input logic [31:0] adr,
                            input logic [31:0] dat, input logic [31:0] exp);
        step_name[step_cnt] = nm;
        step_op[step_cnt]   = op;
        step_adr[step_cnt]  = adr;
        step_dat[step_cnt]  = dat;
        step_exp[step_cnt]  = exp;
        step_cnt++;
    endtask

    task automatic run_table();
        logic [31:0] rd;
        for (int i = 0; i < step_cnt; i++) begin
            case (step_op[i])
                OP_WR: bus_write(step_adr[i], step_dat[i]);
                OP_RD: begin
                    bus_read(step_adr[i], rd);
                    check_word(step_name[i], step_exp[i], rd);
                end
                OP_PIN: check_word(step_name[i], step_exp[i], {16'b0, gpio_out});
                // Two cycles for the input synchronizer
                default: begin
                    @(negedge clk);
                    gpio_in = step_dat[i][14:0];
                    repeat (2) @(negedge clk);
                end
            endcase
        end
    endtask

    task automatic get_frame(output audio_pkg::sample_pair_t f);
        int n;
        n = 0;
        f = '0;
        while (frames.size() == 0 && n < FRAME_TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (frames.size() == 0) begin
            fail_count++;
            $display("ERROR no I2S frame arrived within %0d cycles", FRAME_TIMEOUT);
        end else begin
            f = frames.pop_front();
        end
    endtask

    // Silent frames ahead of the first real one are skipped
    task automatic get_data_frame(output audio_pkg::sample_pair_t f);
        int skipped;
        skipped = 0;
        get_frame(f);
        while (f == '0 && skipped < 3) begin
            skipped++;
            get_frame(f);
        end
    endtask

    task automatic wait_frame_start();
        int   n;
        logic prev;
        logic got;
        n    = 0;
        got  = 1'b0;
        prev = lrclk;
        while (!got && n < FRAME_TIMEOUT) begin
            @(negedge clk);
            n++;
            got  = prev && !lrclk;
            prev = lrclk;
        end
        if (!got) begin
            fail_count++;
            $display("ERROR lrclk did not fall within %0d cycles", FRAME_TIMEOUT);
        end
    endtask

    task automatic check_irq_bit(input string nm, input logic exp);
        logic [31:0] rd;
        bus_read(region_addr(soc_pkg::REGION_GPIO, soc_pkg::GPIO_IN_OFS), rd);
        check_bit(nm, exp, rd[15]);
    endtask

    task automatic push_pair(input audio_pkg::sample_pair_t p);
        bus_write(region_addr(soc_pkg::REGION_AUDIO, audio_pkg::AUDIO_DATA_OFS), p);
        sent.push_back(p);
    endtask

    initial begin
        logic [31:0]             rd;
        logic [31:0]             a_ctrl;
        logic [31:0]             a_stat;
        logic [31:0]             g_out;
        logic [31:0]             g_in;
        audio_pkg::sample_pair_t f;
        int                      n;

        wb_adr   = '0;
        wb_dat_w = '0;
        wb_we    = 1'b0;
        wb_stb   = 1'b0;
        wb_cyc   = 1'b0;
        gpio_in  = '0;
        a_ctrl = region_addr(soc_pkg::REGION_AUDIO, audio_pkg::AUDIO_CTRL_OFS);
        a_stat = region_addr(soc_pkg::REGION_AUDIO, audio_pkg::AUDIO_STATUS_OFS);
        g_out  = region_addr(soc_pkg::REGION_GPIO, soc_pkg::GPIO_OUT_OFS);
        g_in   = region_addr(soc_pkg::REGION_GPIO, soc_pkg::GPIO_IN_OFS);

        n = 0;
        while (rst !== 1'b0 && n < 50) begin
            @(negedge clk);
            n++;
        end
        if (rst !== 1'b0) begin
            fail_count++;
            $display("ERROR reset was never released");
        end

        // GPIO, unmapped regions and CTRL readback, FSM kept disabled
        add_step("gpio_out_write", OP_WR, g_out, 32'h0000a5c3, 32'h0);
        add_step("gpio_out_pin", OP_PIN, 32'h0, 32'h0, 32'h0000a5c3);
        add_step("gpio_out_readback", OP_RD, g_out, 32'h0, 32'h0000a5c3);
        add_step("gpio_in_set_a", OP_SETIN, 32'h0, 32'h00002b6d, 32'h0);
        add_step("gpio_in_read_a", OP_RD, g_in, 32'h0, 32'h00002b6d);
        add_step("gpio_in_set_b", OP_SETIN, 32'h0, 32'h00007fff, 32'h0);
        add_step("gpio_in_read_b", OP_RD, g_in, 32'h0, 32'h00007fff);
        add_step("unmapped_read", OP_RD, 32'h00030000, 32'h0, 32'h0);
        add_step("unmapped_write", OP_WR, 32'h000f0010, 32'hdeadbeef, 32'h0);
        add_step("unmapped_read_after_write", OP_RD, 32'h000f0010, 32'h0, 32'h0);
        add_step("status_after_reset", OP_RD, a_stat, 32'h0, make_status(0, 0, 0, 0));
        add_step("ctrl_write", OP_WR, a_ctrl, 32'habcd5a00, 32'h0);
        add_step("ctrl_readback", OP_RD, a_ctrl, 32'h0, make_ctrl(1'b0, 8'h5a));
        run_table();

        // Streaming while enabled, threshold 3
        bus_write(a_ctrl, make_ctrl(1'b1, 8'd3));
        check_bit("low_pin_after_enable", 1'b1, fifo_low);
        check_irq_bit("low_irq_after_enable", 1'b1);
        bus_read(a_ctrl, rd);
        check_word("ctrl_readback_enabled", make_ctrl(1'b1, 8'd3), rd);
        wait_frame_start();
        frames.delete();
        for (int k = 0; k < 4; k++) begin
            push_pair(random_pair());
            check_bit($sformatf("stream_push%0d_low_pin", k), (k + 1) < 3, fifo_low);
            check_irq_bit($sformatf("stream_push%0d_low_irq", k), (k + 1) < 3);
        end
        get_data_frame(f);
        check_pair("stream_frame0", sent.pop_front(), f);
        for (int k = 1; k < 4; k++) begin
            get_frame(f);
            check_pair($sformatf("stream_frame%0d", k), sent.pop_front(), f);
        end

        // Empty FIFO underruns
        for (int k = 0; k < 2; k++) begin
            get_frame(f);
            check_pair($sformatf("underrun_frame%0d", k), '0, f);
        end
        bus_read(a_stat, rd);
        check_bit("underrun_sticky", 1'b1, rd[audio_pkg::STAT_UNDERRUN_BIT]);
        bus_write(a_ctrl, make_ctrl(1'b0, 8'd3));
        bus_read(a_stat, rd);
        check_word("status_after_ctrl_write", make_status(0, 0, 0, 0), rd);

        // Overfill while disabled, then drain
        for (int k = 0; k < 10; k++) begin
            push_pair(random_pair());
            check_bit($sformatf("fill_push%0d_low_pin", k), 1'b0, fifo_low);
        end
        check_irq_bit("fill_low_irq", 1'b0);
        bus_read(a_stat, rd);
        check_word("status_full_overflow", make_status(8, 0, 0, 1), rd);
        frames.delete();
        bus_write(a_ctrl, make_ctrl(1'b1, 8'd3));
        check_bit("low_pin_after_refill_enable", 1'b0, fifo_low);
        get_data_frame(f);
        check_pair("drain_frame0", sent.pop_front(), f);
        for (int k = 1; k < 8; k++) begin
            get_frame(f);
            check_pair($sformatf("drain_frame%0d", k), sent.pop_front(), f);
        end
        get_frame(f);
        check_pair("drain_no_ninth_frame", '0, f);

        $display("Summary: %0d passed, %0d failed", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// File: build.f
soc_pkg.sv
audio_pkg.sv
wb_if.sv
sample_fifo_if.sv
wb_xbar.sv
audio_regs.sv
sample_fifo.sv
i2s_bit_timer.sv
i2s_tx_fsm.sv
gpio_port.sv
audio_soc_top.sv
tb_clock_gen.sv
tb_audio_soc.sv
